//--- hw/dwcPkg.sv
package dwcPkg;

    //////////////////////////////////////////////////
    // Bus geometry
    //////////////////////////////////////////////////

    // Bytes per master beat and per slave beat
    localparam int wideBytes = 8;
    localparam int narrowBytes = 4;

    // AWSIZE for the slave side
    localparam logic [2:0] narrowSize = 3'd2;

    // Plan buffer entries and the starting credit count
    localparam int planDepth = 4;
    localparam int creditWidth = $clog2(planDepth + 1);

    //////////////////////////////////////////////////
    // Field types
    //////////////////////////////////////////////////

    typedef logic [31:0] addrT;
    typedef logic [3:0] idT;
    typedef logic [7:0] lenT;
    typedef logic [2:0] sizeT;
    typedef logic [1:0] burstT;
    typedef logic [1:0] respT;

    typedef logic [wideBytes*8-1:0] wideDataT;
    typedef logic [wideBytes-1:0] wideStrbT;
    typedef logic [narrowBytes*8-1:0] narrowDataT;
    typedef logic [narrowBytes-1:0] narrowStrbT;

    typedef logic [creditWidth-1:0] creditT;

    //////////////////////////////////////////////////
    // Channel payloads
    //////////////////////////////////////////////////

    // Write address for INCR bursts only
    typedef struct packed {
        idT id;
        addrT addr;
        lenT len;
        sizeT size;
        burstT burst;
    } awReqT;

    typedef struct packed {
        wideDataT data;
        wideStrbT strb;
        logic last;
    } wideBeatT;

    typedef struct packed {
        narrowDataT data;
        narrowStrbT strb;
        logic last;
    } narrowBeatT;

    // One entry per burst for the data path
    typedef struct packed {
        logic startHigh;
        lenT slaveLen;
    } beatPlanT;

    typedef struct packed {
        idT id;
        respT resp;
    } bRespT;

    // Which half of the held wide beat goes out next
    typedef enum logic [1:0] {
        idle,
        lowHalf,
        highHalf
    } narrowStateT;

endpackage

//--- hw/writeCmdConverter.sv
`timescale 1ns/100ps

module writeCmdConverter (
    input  logic              ACLK,
    input  logic              rstN,
    input  logic              masterAwValid,
    output logic              masterAwReady,
    input  dwcPkg::awReqT     masterAw,
    output logic              slaveAwValid,
    input  logic              slaveAwReady,
    output dwcPkg::awReqT     slaveAw,
    output logic              planPush,
    output dwcPkg::beatPlanT  plan,
    input  logic              creditReturn
);

    dwcPkg::creditT credits;
    logic startHigh;
    dwcPkg::lenT slaveLen;

    //////////////////////////////////////////////////
    // Burst length on the narrow side
    //////////////////////////////////////////////////

    // Address bit that selects the upper half of a wide beat
    assign startHigh = masterAw.addr[$clog2(dwcPkg::narrowBytes)];

    // Two slave beats per master beat and one less for an odd start
    assign slaveLen = {masterAw.len[6:0], 1'b1} - dwcPkg::lenT'(startHigh);

    assign plan.startHigh = startHigh;
    assign plan.slaveLen = slaveLen;

    //////////////////////////////////////////////////
    // Handshake
    //////////////////////////////////////////////////

    // Need a free plan slot and room in the AW register
    assign masterAwReady = (credits != '0) && (!slaveAwValid || slaveAwReady);
    assign planPush = masterAwValid && masterAwReady;

    // Credit counter
    always_ff @(posedge ACLK or negedge rstN)
    begin
        if (!rstN)
        begin
            credits <= dwcPkg::creditT'(dwcPkg::planDepth);
        end
        else
        begin
            case ({planPush, creditReturn})
                2'b10:
                begin
                    credits <= credits - 1'b1;
                end
                2'b01:
                begin
                    credits <= credits + 1'b1;
                end
                default:
                begin
                    credits <= credits;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Slave AW register
    //////////////////////////////////////////////////

    always_ff @(posedge ACLK or negedge rstN)
    begin
        if (!rstN)
        begin
            slaveAwValid <= 1'b0;
        end
        else if (planPush)
        begin
            slaveAwValid <= 1'b1;
        end
        else if (slaveAwReady)
        begin
            slaveAwValid <= 1'b0;
        end
    end

    always_ff @(posedge ACLK)
    begin
        if (planPush)
        begin
            slaveAw.id <= masterAw.id;
            slaveAw.addr <= masterAw.addr;
            slaveAw.len <= slaveLen;
            slaveAw.size <= dwcPkg::narrowSize;
            slaveAw.burst <= masterAw.burst;
        end
    end

endmodule

//--- hw/beatPlanFifo.sv
`timescale 1ns/100ps

module beatPlanFifo (
    input  logic              ACLK,
    input  logic              rstN,
    input  logic              planPush,
    input  dwcPkg::beatPlanT  plan,
    output logic              planValid,
    output dwcPkg::beatPlanT  planHead,
    input  logic              planPop,
    output logic              creditReturn
);

    dwcPkg::beatPlanT planMem [dwcPkg::planDepth];
    logic [$clog2(dwcPkg::planDepth)-1:0] wrPtr;
    logic [$clog2(dwcPkg::planDepth)-1:0] rdPtr;
    dwcPkg::creditT count;
    logic doPop;

    // Producer owns the space check through its credits
    assign planValid = (count != '0);
    assign planHead = planMem[rdPtr];
    assign doPop = planPop && planValid;

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    always_ff @(posedge ACLK)
    begin
        if (planPush)
        begin
            planMem[wrPtr] <= plan;
        end
    end

    //////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////

    always_ff @(posedge ACLK or negedge rstN)
    begin
        if (!rstN)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (planPush)
            begin
                wrPtr <= (wrPtr == ($bits(wrPtr))'(dwcPkg::planDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop)
            begin
                rdPtr <= (rdPtr == ($bits(rdPtr))'(dwcPkg::planDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            // Simultaneous push and pop keep the count
            if (planPush && !doPop)
            begin
                count <= count + 1'b1;
            end
            else if (doPop && !planPush)
            begin
                count <= count - 1'b1;
            end
        end
    end

    // One credit back per pop a cycle later
    always_ff @(posedge ACLK or negedge rstN)
    begin
        if (!rstN)
        begin
            creditReturn <= 1'b0;
        end
        else
        begin
            creditReturn <= doPop;
        end
    end

endmodule

//--- hw/writeDataNarrower.sv
`timescale 1ns/100ps

module writeDataNarrower (
    input  logic                ACLK,
    input  logic                rstN,
    input  logic                planValid,
    input  dwcPkg::beatPlanT    planHead,
    output logic                planPop,
    input  logic                masterWValid,
    output logic                masterWReady,
    input  dwcPkg::wideBeatT    masterW,
    output logic                slaveWValid,
    input  logic                slaveWReady,
    output dwcPkg::narrowBeatT  slaveW
);

    dwcPkg::narrowStateT state;
    dwcPkg::beatPlanT curPlan;
    dwcPkg::lenT beatCount;
    dwcPkg::wideDataT beatData;
    dwcPkg::wideStrbT beatStrb;
    logic beatFull;
    logic upperSel;
    logic lastBeat;
    logic wAccept;
    logic wTake;

    //////////////////////////////////////////////////
    // Output half selection
    //////////////////////////////////////////////////

    assign upperSel = (state == dwcPkg::highHalf);
    assign lastBeat = (beatCount == curPlan.slaveLen);

    assign slaveWValid = beatFull;
    assign wTake = beatFull && slaveWReady;

    always_comb
    begin
        if (upperSel)
        begin
            slaveW.data = beatData[dwcPkg::narrowBytes*8 +: dwcPkg::narrowBytes*8];
            slaveW.strb = beatStrb[dwcPkg::narrowBytes +: dwcPkg::narrowBytes];
        end
        else
        begin
            slaveW.data = beatData[0 +: dwcPkg::narrowBytes*8];
            slaveW.strb = beatStrb[0 +: dwcPkg::narrowBytes];
        end
        // The final narrow beat is always an upper half
        slaveW.last = lastBeat;
    end

    //////////////////////////////////////////////////
    // Master side acceptance
    //////////////////////////////////////////////////

    // Refill only while a plan is active and not past its end
    assign masterWReady = (state != dwcPkg::idle) &&
                          (!beatFull || (upperSel && slaveWReady && !lastBeat));
    assign wAccept = masterWValid && masterWReady;

    assign planPop = (state == dwcPkg::idle) && planValid;

    // Wide beat payload
    always_ff @(posedge ACLK)
    begin
        if (wAccept)
        begin
            beatData <= masterW.data;
            beatStrb <= masterW.strb;
        end
    end

    //////////////////////////////////////////////////
    // Half sequencing
    //////////////////////////////////////////////////

    always_ff @(posedge ACLK or negedge rstN)
    begin
        if (!rstN)
        begin
            state <= dwcPkg::idle;
            curPlan <= '0;
            beatCount <= '0;
            beatFull <= 1'b0;
        end
        else
        begin
            case (state)
                dwcPkg::idle:
                begin
                    if (planValid)
                    begin
                        curPlan <= planHead;
                        beatCount <= '0;
                        state <= planHead.startHigh ? dwcPkg::highHalf : dwcPkg::lowHalf;
                    end
                end
                dwcPkg::lowHalf:
                begin
                    if (wTake)
                    begin
                        beatCount <= beatCount + 1'b1;
                        state <= dwcPkg::highHalf;
                    end
                end
                dwcPkg::highHalf:
                begin
                    if (wTake)
                    begin
                        beatCount <= beatCount + 1'b1;
                        state <= lastBeat ? dwcPkg::idle : dwcPkg::lowHalf;
                    end
                end
                default:
                begin
                    state <= dwcPkg::idle;
                end
            endcase

            // Register empties once its upper half has gone
            if (wAccept)
            begin
                beatFull <= 1'b1;
            end
            else if (wTake && upperSel)
            begin
                beatFull <= 1'b0;
            end
        end
    end

endmodule

//--- hw/writeDownsizer.sv
`timescale 1ns/100ps

module writeDownsizer (
    input  logic                ACLK,
    input  logic                rstN,
    // Master side
    input  logic                masterAwValid,
    output logic                masterAwReady,
    input  dwcPkg::awReqT       masterAw,
    input  logic                masterWValid,
    output logic                masterWReady,
    input  dwcPkg::wideBeatT    masterW,
    output logic                masterBValid,
    input  logic                masterBReady,
    output dwcPkg::bRespT       masterB,
    // Slave side
    output logic                slaveAwValid,
    input  logic                slaveAwReady,
    output dwcPkg::awReqT       slaveAw,
    output logic                slaveWValid,
    input  logic                slaveWReady,
    output dwcPkg::narrowBeatT  slaveW,
    input  logic                slaveBValid,
    output logic                slaveBReady,
    input  dwcPkg::bRespT       slaveB
);

    logic planPush;
    dwcPkg::beatPlanT plan;
    logic creditReturn;
    logic planValid;
    dwcPkg::beatPlanT planHead;
    logic planPop;

    //////////////////////////////////////////////////
    // Address path and plan buffer
    //////////////////////////////////////////////////

    writeCmdConverter cmdConv (
        .ACLK          (ACLK),
        .rstN          (rstN),
        .masterAwValid (masterAwValid),
        .masterAwReady (masterAwReady),
        .masterAw      (masterAw),
        .slaveAwValid  (slaveAwValid),
        .slaveAwReady  (slaveAwReady),
        .slaveAw       (slaveAw),
        .planPush      (planPush),
        .plan          (plan),
        .creditReturn  (creditReturn)
    );

    beatPlanFifo planFifo (
        .ACLK         (ACLK),
        .rstN         (rstN),
        .planPush     (planPush),
        .plan         (plan),
        .planValid    (planValid),
        .planHead     (planHead),
        .planPop      (planPop),
        .creditReturn (creditReturn)
    );

    // Data path
    writeDataNarrower dataNarrow (
        .ACLK         (ACLK),
        .rstN         (rstN),
        .planValid    (planValid),
        .planHead     (planHead),
        .planPop      (planPop),
        .masterWValid (masterWValid),
        .masterWReady (masterWReady),
        .masterW      (masterW),
        .slaveWValid  (slaveWValid),
        .slaveWReady  (slaveWReady),
        .slaveW       (slaveW)
    );

    // B passes straight through with one response per burst
    assign masterBValid = slaveBValid;
    assign slaveBReady = masterBReady;
    assign masterB = slaveB;

endmodule

//--- verification/writeDownsizer_properties.sv
`timescale 1ns/100ps

module writeDownsizer_properties (
    input logic                ACLK,
    input logic                rstN,
    input logic                masterAwValid,
    input logic                masterAwReady,
    input dwcPkg::awReqT       masterAw,
    input logic                masterWValid,
    input logic                masterWReady,
    input dwcPkg::wideBeatT    masterW,
    input logic                slaveAwValid,
    input logic                slaveAwReady,
    input dwcPkg::awReqT       slaveAw,
    input logic                slaveWValid,
    input logic                slaveWReady,
    input dwcPkg::narrowBeatT  slaveW
);

    // Master lengths of accepted bursts in arrival order
    dwcPkg::lenT lenRing [8];
    logic [2:0] wrIdx;
    logic [2:0] rdIdx;
    dwcPkg::lenT wideCount;
    logic planDone;

    assign planDone = (wideCount == lenRing[rdIdx]);

    always_ff @(posedge ACLK)
    begin
        if (masterAwValid && masterAwReady)
        begin
            lenRing[wrIdx] <= masterAw.len;
        end
    end

    // Wide beats seen in the burst at the head
    always_ff @(posedge ACLK or negedge rstN)
    begin
        if (!rstN)
        begin
            wrIdx <= '0;
            rdIdx <= '0;
            wideCount <= '0;
        end
        else
        begin
            if (masterAwValid && masterAwReady)
            begin
                wrIdx <= wrIdx + 3'd1;
            end
            if (masterWValid && masterWReady)
            begin
                if (planDone)
                begin
                    rdIdx <= rdIdx + 3'd1;
                    wideCount <= '0;
                end
                else
                begin
                    wideCount <= wideCount + 8'd1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Slave side handshake rules
    //////////////////////////////////////////////////

    awHold: assert property (@(posedge ACLK) disable iff (!rstN)
        (slaveAwValid && !slaveAwReady) |=> (slaveAwValid && $stable(slaveAw)))
        else $error("slave AW dropped or changed before ready");

    wHold: assert property (@(posedge ACLK) disable iff (!rstN)
        (slaveWValid && !slaveWReady) |=> (slaveWValid && $stable(slaveW)))
        else $error("slave W dropped or changed before ready");

    awSize: assert property (@(posedge ACLK) disable iff (!rstN)
        slaveAwValid |-> (slaveAw.size == dwcPkg::narrowSize))
        else $error("slave AW size is not the narrow size");

    // Master WLAST only on the beat that ends the plan
    wLastPlan: assert property (@(posedge ACLK) disable iff (!rstN)
        (masterWValid && masterWReady) |-> (masterW.last == planDone))
        else $error("master WLAST does not match the burst length");

endmodule

//--- verification/writeDownsizerTb.sv
`timescale 1ns/100ps

module writeDownsizerTb;

    localparam int numBursts = 40;
    localparam int timeoutCycles = numBursts * 16 * 8 + 200;

    logic ACLK;
    logic rstN;
    logic masterAwValid;
    logic masterAwReady;
    dwcPkg::awReqT masterAw;
    logic masterWValid;
    logic masterWReady;
    dwcPkg::wideBeatT masterW;
    logic masterBValid;
    logic masterBReady;
    dwcPkg::bRespT masterB;
    logic slaveAwValid;
    logic slaveAwReady;
    dwcPkg::awReqT slaveAw;
    logic slaveWValid;
    logic slaveWReady;
    dwcPkg::narrowBeatT slaveW;
    logic slaveBValid;
    logic slaveBReady;
    dwcPkg::bRespT slaveB;

    dwcPkg::awReqT burstReq [numBursts];
    dwcPkg::wideBeatT masterBeats[$];
    dwcPkg::awReqT expAw[$];
    dwcPkg::narrowBeatT expBeats[$];
    dwcPkg::respT respQ[$];
    dwcPkg::idT slaveIds[$];
    logic [15:0] lfsrState;
    int bCount;
    int cycles;
    int awErrors;
    int beatErrors;
    int respErrors;
    int otherErrors;

    writeDownsizer dut (
        .ACLK          (ACLK),
        .rstN          (rstN),
        .masterAwValid (masterAwValid),
        .masterAwReady (masterAwReady),
        .masterAw      (masterAw),
        .masterWValid  (masterWValid),
        .masterWReady  (masterWReady),
        .masterW       (masterW),
        .masterBValid  (masterBValid),
        .masterBReady  (masterBReady),
        .masterB       (masterB),
        .slaveAwValid  (slaveAwValid),
        .slaveAwReady  (slaveAwReady),
        .slaveAw       (slaveAw),
        .slaveWValid   (slaveWValid),
        .slaveWReady   (slaveWReady),
        .slaveW        (slaveW),
        .slaveBValid   (slaveBValid),
        .slaveBReady   (slaveBReady),
        .slaveB        (slaveB)
    );

    bind writeDownsizer writeDownsizer_properties props (
        .ACLK(ACLK), .rstN(rstN),
        .masterAwValid(masterAwValid), .masterAwReady(masterAwReady), .masterAw(masterAw),
        .masterWValid(masterWValid), .masterWReady(masterWReady), .masterW(masterW),
        .slaveAwValid(slaveAwValid), .slaveAwReady(slaveAwReady), .slaveAw(slaveAw),
        .slaveWValid(slaveWValid), .slaveWReady(slaveWReady), .slaveW(slaveW)
    );

    initial
    begin
        ACLK = 1'b0;
        forever #10 ACLK = ~ACLK;
    end

    //////////////////////////////////////////////////
    // Random source and reference model
    //////////////////////////////////////////////////

    function automatic logic [15:0] galoisStep(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit with the oldest bit on top
    function automatic logic [63:0] randBits(input int n);
        logic [63:0] r;
        r = '0;
        for (int k = 0; k < n; k++)
        begin
            r = {r[62:0], lfsrState[0]};
            lfsrState = galoisStep(lfsrState);
        end
        return r;
    endfunction

    // Expected slave AW with the narrow beats queued in order
    function automatic dwcPkg::awReqT expandBurst(input dwcPkg::awReqT req, input int first);
        dwcPkg::awReqT aw;
        dwcPkg::wideBeatT wide;
        dwcPkg::narrowBeatT nb;
        int total;
        int sent;
        logic oddStart;
        oddStart = req.addr[2];
        total = 2 * (int'(req.len) + 1) - (oddStart ? 1 : 0);
        aw = req;
        aw.size = dwcPkg::narrowSize;
        aw.len = dwcPkg::lenT'(total - 1);
        sent = 0;
        for (int k = 0; k <= int'(req.len); k++)
        begin
            wide = masterBeats[first + k];
            if (!(k == 0 && oddStart))
            begin
                sent++;
                nb.data = wide.data[31:0];
                nb.strb = wide.strb[3:0];
                nb.last = (sent == total);
                expBeats.push_back(nb);
            end
            sent++;
            nb.data = wide.data[63:32];
            nb.strb = wide.strb[7:4];
            nb.last = (sent == total);
            expBeats.push_back(nb);
        end
        return aw;
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic checkAw(input dwcPkg::awReqT got, input dwcPkg::awReqT exp);
        if (got !== exp)
        begin
            awErrors++;
            $display("mismatch at %0t: slave AW id %h addr %h len %0d size %0d burst %0d,",
                     $time, got.id, got.addr, got.len, got.size, got.burst);
            $display("    expected id %h addr %h len %0d size %0d burst %0d",
                     exp.id, exp.addr, exp.len, exp.size, exp.burst);
        end
    endtask

    task automatic checkBeat(input dwcPkg::narrowBeatT got, input dwcPkg::narrowBeatT exp);
        if (got !== exp)
        begin
            beatErrors++;
            $display("mismatch at %0t: slave W data %h strb %b last %b, expected %h %b %b",
                     $time, got.data, got.strb, got.last, exp.data, exp.strb, exp.last);
        end
    endtask

    task automatic checkResp(input dwcPkg::bRespT got, input dwcPkg::bRespT exp);
        if (got !== exp)
        begin
            respErrors++;
            $display("mismatch at %0t: master B id %h resp %0d, expected id %h resp %0d",
                     $time, got.id, got.resp, exp.id, exp.resp);
        end
    endtask

    //////////////////////////////////////////////////
    // Master drivers
    //////////////////////////////////////////////////

    task automatic driveAw();
        for (int i = 0; i < numBursts; i++)
        begin
            masterAw <= burstReq[i];
            masterAwValid <= 1'b1;
            @(posedge ACLK);
            while (!masterAwReady)
                @(posedge ACLK);
        end
        masterAwValid <= 1'b0;
    endtask

    task automatic driveW();
        for (int n = 0; n < masterBeats.size(); n++)
        begin
            masterW <= masterBeats[n];
            masterWValid <= 1'b1;
            @(posedge ACLK);
            while (!masterWReady)
                @(posedge ACLK);
        end
        masterWValid <= 1'b0;
    endtask

    // Slave with random back-pressure and one B per completed burst
    initial
    begin
        dwcPkg::bRespT nextB;
        logic bPending;
        int wDone;
        int bIssued;
        logic [63:0] bits;
        wDone = 0;
        bIssued = 0;
        @(posedge rstN);
        forever
        begin
            @(posedge ACLK);
            if (slaveAwValid && slaveAwReady)
                slaveIds.push_back(slaveAw.id);
            if (slaveWValid && slaveWReady && slaveW.last)
                wDone++;
            bPending = slaveBValid && !slaveBReady;
            if (slaveBValid && slaveBReady)
                slaveBValid <= 1'b0;
            if (!bPending && bIssued < wDone && slaveIds.size() > 0)
            begin
                bits = randBits(2);
                nextB.id = slaveIds.pop_front();
                nextB.resp = bits[1:0];
                respQ.push_back(nextB.resp);
                slaveB <= nextB;
                slaveBValid <= 1'b1;
                bIssued++;
            end
            slaveAwReady <= (randBits(2) != 64'd0);
            slaveWReady <= (randBits(2) != 64'd0);
            masterBReady <= (randBits(1) != 64'd0);
        end
    end

    // Comparison of every slave and master handshake
    always @(posedge ACLK)
    begin
        dwcPkg::bRespT expB;
        if (slaveAwValid && slaveAwReady)
        begin
            if (expAw.size() == 0)
            begin
                otherErrors++;
                $display("Error at %0t: slave AW issued with no burst left", $time);
            end
            else
                checkAw(slaveAw, expAw.pop_front());
        end
        if (slaveWValid && slaveWReady)
        begin
            if (expBeats.size() == 0)
            begin
                otherErrors++;
                $display("Error at %0t: extra slave W beat", $time);
            end
            else
                checkBeat(slaveW, expBeats.pop_front());
        end
        if (masterBValid && masterBReady)
        begin
            if (bCount >= numBursts || respQ.size() == 0)
            begin
                otherErrors++;
                $display("Error at %0t: master B without a slave response", $time);
            end
            else
            begin
                expB.id = burstReq[bCount].id;
                expB.resp = respQ.pop_front();
                checkResp(masterB, expB);
            end
            bCount++;
        end
    end

    initial
    begin
        cycles = 0;
        while (cycles < timeoutCycles)
        begin
            @(posedge ACLK);
            cycles++;
        end
        $display("Error: run timed out after %0d cycles, %0d of %0d responses seen",
                 cycles, bCount, numBursts);
        $display("Errors: aw %0d, beat %0d, resp %0d, other %0d",
                 awErrors, beatErrors, respErrors, otherErrors + 1);
        $display("Regression failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // Stimulus and final report
    //////////////////////////////////////////////////

    initial
    begin
        dwcPkg::awReqT req;
        dwcPkg::wideBeatT beat;
        logic [63:0] bits;
        int base;
        rstN = 1'b0;
        masterAwValid = 1'b0;
        masterAw = '0;
        masterWValid = 1'b0;
        masterW = '0;
        masterBReady = 1'b0;
        slaveAwReady = 1'b0;
        slaveWReady = 1'b0;
        slaveBValid = 1'b0;
        slaveB = '0;
        lfsrState = 16'd58;
        bCount = 0;
        awErrors = 0;
        beatErrors = 0;
        respErrors = 0;
        otherErrors = 0;

        // INCR bursts of 64-bit beats from a 4-byte aligned start
        for (int i = 0; i < numBursts; i++)
        begin
            bits = randBits(4);
            req.id = bits[3:0];
            bits = randBits(30);
            req.addr = {bits[29:0], 2'b00};
            bits = randBits(3);
            req.len = {5'd0, bits[2:0]};
            req.size = 3'd3;
            req.burst = 2'b01;
            burstReq[i] = req;
            base = masterBeats.size();
            for (int j = 0; j <= int'(req.len); j++)
            begin
                beat.data = randBits(64);
                bits = randBits(8);
                beat.strb = bits[7:0];
                beat.last = (j == int'(req.len));
                masterBeats.push_back(beat);
            end
            expAw.push_back(expandBurst(req, base));
        end

        repeat (3) @(posedge ACLK);
        rstN <= 1'b1;
        fork
            driveAw();
            driveW();
        join
        while (bCount < numBursts)
            @(posedge ACLK);
        repeat (4) @(posedge ACLK);

        if (expAw.size() != 0 || expBeats.size() != 0)
        begin
            otherErrors++;
            $display("Error: %0d slave AWs and %0d slave beats never arrived",
                     expAw.size(), expBeats.size());
        end
        $display("Errors: aw %0d, beat %0d, resp %0d, other %0d",
                 awErrors, beatErrors, respErrors, otherErrors);
        if (awErrors + beatErrors + respErrors + otherErrors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

//--- project.f
hw/dwcPkg.sv
hw/writeCmdConverter.sv
hw/beatPlanFifo.sv
hw/writeDataNarrower.sv
hw/writeDownsizer.sv
verification/writeDownsizer_properties.sv
verification/writeDownsizerTb.sv

//--- Makefile
# Verilator simulation of the AXI write downsizer

VERILATOR ?= verilator
TOP ?= writeDownsizerTb
LOG ?= sim.log
FILELIST ?= project.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --assert --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR) -o V$(TOP)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
